// File: build.f
hdl/mem_pkg.sv
hdl/multicycle_memory.sv
hdl/icache.sv
hdl/dcache.sv
hdl/memory.sv
verif/memory_chk.sv
verif/memory_scoreboard.sv
verif/memory_tb.sv

// File: Bender.yml
package:
  name: memory_subsystem

sources:
  - hdl/mem_pkg.sv
  - hdl/multicycle_memory.sv
  - hdl/icache.sv
  - hdl/dcache.sv
  - hdl/memory.sv
  - target: simulation
    files:
      - verif/memory_chk.sv
      - verif/memory_scoreboard.sv
      - verif/memory_tb.sv

// File: verif/memory_tb.sv
`timescale 1ns/1ns
`default_nettype none

module memory_tb;
   import mem_pkg::*;

   localparam int MEM_LATENCY = 4;
   localparam int MEM_DEPTH_W = 10;
   localparam int CLK_PERIOD  = 20;
   localparam int PRELOAD_N   = 1024;
   localparam int OPS_N       = 2000;
   localparam longint TIMEOUT_NS =
      longint'(PRELOAD_N + OPS_N * 8) * (MEM_LATENCY + 3) * CLK_PERIOD;

   logic              clk;
   logic              rst_n;
   logic [WORD_W-1:0] instr_addr;
   logic [WORD_W-1:0] instr;
   logic              i_busy;
   logic              d_mem_en;
   logic              d_wr_en;
   logic [WORD_W-1:0] d_addr;
   logic [WORD_W-1:0] d_wdata;
   logic [WORD_W-1:0] d_rdata;
   logic              d_busy;
   logic              fetch_chk;
   integer            seed;
   int                tb_err_cnt = 0;
   int                sb_err_cnt;
   int                sb_chk_cnt;
   logic [WORD_W-1:0] last_iaddr;
   logic [WORD_W-1:0] last_daddr;

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   memory #(
      .MEM_LATENCY (MEM_LATENCY),
      .MEM_DEPTH_W (MEM_DEPTH_W)
   ) dut0 (
      .clk          (clk),
      .i_rst_n      (rst_n),
      .i_instr_addr (instr_addr),
      .o_instr      (instr),
      .o_i_busy     (i_busy),
      .i_d_mem_en   (d_mem_en),
      .i_d_wr_en    (d_wr_en),
      .i_d_addr     (d_addr),
      .i_d_wdata    (d_wdata),
      .o_d_rdata    (d_rdata),
      .o_d_busy     (d_busy)
   );

   memory_scoreboard #(.MEM_DEPTH_W (MEM_DEPTH_W)) sb0 (
      .clk          (clk),
      .i_rst_n      (rst_n),
      .i_fetch_chk  (fetch_chk),
      .i_instr_addr (instr_addr),
      .i_instr      (instr),
      .i_i_busy     (i_busy),
      .i_d_mem_en   (d_mem_en),
      .i_d_wr_en    (d_wr_en),
      .i_d_addr     (d_addr),
      .i_d_wdata    (d_wdata),
      .i_d_rdata    (d_rdata),
      .i_d_busy     (d_busy),
      .o_err_cnt    (sb_err_cnt),
      .o_chk_cnt    (sb_chk_cnt)
   );

   bind memory memory_chk chk0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_mem_en    (mem_en),
      .i_mem_valid (mem_valid),
      .i_gnt       (gnt_q),
      .i_gnt_sel   (gnt_sel_q),
      .i_ic_valid  (ic_valid),
      .i_dc_valid  (dc_valid),
      .i_i_busy    (o_i_busy),
      .i_d_busy    (o_d_busy)
   );

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // half the time stay in the last line so hits show up
   function automatic logic [WORD_W-1:0] pick_addr(input logic [WORD_W-1:0] last,
                                                   input int unsigned base);
      logic [WORD_W-1:0] a;
      if (rand_below(2) == 0) begin
         a = {last[WORD_W-1:OFFSET_W], OFFSET_W'(rand_below(LINE_WORDS))};
      end else begin
         a = WORD_W'(base + rand_below(512));
      end
      return a;
   endfunction

   // start a fetch, a data access or both, then wait for each busy to drop
   task automatic access(input logic do_fetch, input logic do_data, input logic wr,
                         input logic [WORD_W-1:0] iaddr, input logic [WORD_W-1:0] daddr,
                         input logic [WORD_W-1:0] wdata);
      logic i_done;
      logic d_done;
      int   cyc;
      int   i_fall;
      int   d_fall;
      i_done = !do_fetch;
      d_done = !do_data;
      cyc    = 0;
      i_fall = 0;
      d_fall = 0;
      @(posedge clk);
      if (do_fetch) begin
         instr_addr <= iaddr;
         fetch_chk  <= 1'b1;
      end
      if (do_data) begin
         d_mem_en <= 1'b1;
         d_wr_en  <= wr;
         d_addr   <= daddr;
         d_wdata  <= wdata;
      end
      while (!(i_done && d_done)) begin
         @(negedge clk);
         cyc++;
         if (!i_done && !i_busy) begin
            i_done = 1'b1;
            i_fall = cyc;
         end
         if (!d_done && !d_busy) begin
            d_done = 1'b1;
            d_fall = cyc;
         end
         @(posedge clk);
         if (d_done) d_mem_en <= 1'b0;   // request ends with its done cycle
      end
      // a hit is done in the first cycle, so both missed only when both fell later
      if (do_fetch && do_data && (d_fall > 1) && (i_fall > d_fall)) begin
         tb_err_cnt++;
         $display("ERROR at %0t ns: instruction busy fell after data busy on a shared miss",
                  $time);
      end
   endtask

   task automatic finish_run();
      int total;
      total = tb_err_cnt + sb_err_cnt + dut0.chk0.fail_cnt;
      $display("errors: testbench %0d, scoreboard %0d, assertions %0d (%0d data checks)",
               tb_err_cnt, sb_err_cnt, dut0.chk0.fail_cnt, sb_chk_cnt);
      if (total == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   endtask

   initial begin
      int unsigned       kind;
      logic [WORD_W-1:0] iaddr;
      logic [WORD_W-1:0] daddr;
      logic [WORD_W-1:0] wdata;
      seed       = 32'h7c3f2842;
      rst_n      = 1'b0;
      instr_addr = 16'h03fc;   // parked outside the fetch region during preload
      d_mem_en   = 1'b0;
      d_wr_en    = 1'b0;
      d_addr     = '0;
      d_wdata    = '0;
      fetch_chk  = 1'b0;
      last_iaddr = 16'h0000;
      last_daddr = 16'h0200;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (i_busy || d_busy) begin
         tb_err_cnt++;
         $display("ERROR at %0t ns: busy high right after reset, before any access", $time);
      end
      @(negedge clk);
      if (!i_busy) begin
         tb_err_cnt++;
         $display("ERROR at %0t ns: first fetch after reset did not miss", $time);
      end
      for (int a = 0; a < PRELOAD_N; a++) begin
         access(1'b0, 1'b1, 1'b1, '0, WORD_W'(a), WORD_W'(rand_below(65536)));
      end
      for (int n = 0; n < OPS_N; n++) begin
         kind  = rand_below(8);
         iaddr = pick_addr(last_iaddr, 0);
         daddr = pick_addr(last_daddr, 512);
         wdata = WORD_W'(rand_below(65536));
         case (kind)
            0, 1: access(1'b1, 1'b0, 1'b0, iaddr, daddr, wdata);
            2, 3: access(1'b0, 1'b1, 1'b0, iaddr, daddr, wdata);
            4, 7: access(1'b0, 1'b1, 1'b1, iaddr, daddr, wdata);
            5: begin   // line in, write hit, read back
               access(1'b0, 1'b1, 1'b0, iaddr, daddr, wdata);
               access(1'b0, 1'b1, 1'b1, iaddr, daddr, wdata);
               access(1'b0, 1'b1, 1'b0, iaddr, daddr, wdata);
            end
            default: access(1'b1, 1'b1, 1'b0, iaddr, daddr, wdata);   // both at once
         endcase
         if (kind inside {0, 1, 6}) last_iaddr = iaddr;
         if (!(kind inside {0, 1})) last_daddr = daddr;
         repeat (rand_below(3)) @(posedge clk);
      end
      repeat (5) @(posedge clk);
      if (sb_chk_cnt == 0) begin
         tb_err_cnt++;
         $display("ERROR: the scoreboard compared no data at all");
      end
      finish_run();
   end

   // bound from the worst case length of every access
   initial begin
      #(TIMEOUT_NS);
      tb_err_cnt++;
      $display("ERROR at %0t ns: run timed out waiting for the DUT", $time);
      finish_run();
   end

endmodule

`default_nettype wire

// File: verif/memory_scoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module memory_scoreboard #(
   parameter int MEM_DEPTH_W = 10
) (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_fetch_chk,    // fetch region holds preloaded data
   input  logic [mem_pkg::WORD_W-1:0] i_instr_addr,
   input  logic [mem_pkg::WORD_W-1:0] i_instr,
   input  logic                       i_i_busy,
   input  logic                       i_d_mem_en,
   input  logic                       i_d_wr_en,
   input  logic [mem_pkg::WORD_W-1:0] i_d_addr,
   input  logic [mem_pkg::WORD_W-1:0] i_d_wdata,
   input  logic [mem_pkg::WORD_W-1:0] i_d_rdata,
   input  logic                       i_d_busy,
   output int                         o_err_cnt,
   output int                         o_chk_cnt
);
   import mem_pkg::*;

   localparam int DEPTH = 2 ** MEM_DEPTH_W;

   logic [WORD_W-1:0] model_q [0:DEPTH-1];
   logic [DEPTH-1:0]  known_q   = '0;    // words written so far
   logic              prev_busy = 1'b1;
   logic [WORD_W-1:0] prev_addr = '0;
   int                err_cnt   = 0;
   int                chk_cnt   = 0;

   assign o_err_cnt = err_cnt;
   assign o_chk_cnt = chk_cnt;

   task automatic compare(input string name, input logic [WORD_W-1:0] addr,
                          input logic [WORD_W-1:0] got);
      logic [MEM_DEPTH_W-1:0] idx;
      idx = addr[MEM_DEPTH_W-1:0];   // memory ignores the high bits
      chk_cnt++;
      if (!known_q[idx]) begin
         err_cnt++;
         $display("ERROR at %0t ns: %s read address %h, which was never written",
                  $time, name, addr);
      end else if (got !== model_q[idx]) begin
         err_cnt++;
         $display("CHECK FAILED at %0t ns: %s expected %h, got %h (address %h)",
                  $time, name, model_q[idx], got, addr);
      end
   endtask

   // mid cycle, inputs and outputs are settled
   always @(negedge clk) begin
      if (i_rst_n) begin
         if (i_d_mem_en && !i_d_busy) begin
            if (i_d_wr_en) begin
               model_q[i_d_addr[MEM_DEPTH_W-1:0]] = i_d_wdata;   // write just completed
               known_q[i_d_addr[MEM_DEPTH_W-1:0]] = 1'b1;
            end else begin
               compare("o_d_rdata", i_d_addr, i_d_rdata);
            end
         end
         // once per fill end or per new hit address
         if (i_fetch_chk && !i_i_busy && (prev_busy || (i_instr_addr != prev_addr))) begin
            compare("o_instr", i_instr_addr, i_instr);
         end
         prev_busy = i_i_busy;
         prev_addr = i_instr_addr;
      end
   end

endmodule

`default_nettype wire

// File: verif/memory_chk.sv
`timescale 1ns/1ns
`default_nettype none

module memory_chk (
   input logic clk,
   input logic i_rst_n,
   input logic i_mem_en,
   input logic i_mem_valid,
   input logic i_gnt,
   input logic i_gnt_sel,     // high for the instruction side
   input logic i_ic_valid,
   input logic i_dc_valid,
   input logic i_i_busy,
   input logic i_d_busy
);

   int fail_cnt = 0;

   // start pulse never lasts two cycles
   en_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_en |=> !i_mem_en)
      else begin
         $error("memory enable held high for more than one cycle");
         fail_cnt++;
      end

   // the done pulse goes to the owner of the grant and nowhere else
   valid_route: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_mem_valid |-> i_gnt && (i_ic_valid == i_gnt_sel) && (i_dc_valid == !i_gnt_sel))
      else begin
         $error("memory valid routed to a cache without the grant");
         fail_cnt++;
      end

   // sampled mid cycle, reset values settle on the first edge
   idle_in_reset: assert property (@(negedge clk)
      !i_rst_n |-> !i_i_busy && !i_d_busy)
      else begin
         $error("busy output high while reset is asserted");
         fail_cnt++;
      end

endmodule

`default_nettype wire

// File: hdl/memory.sv
`timescale 1ns/1ns
`default_nettype none

module memory #(
   parameter int MEM_LATENCY = 4,
   parameter int MEM_DEPTH_W = 10
) (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic [mem_pkg::WORD_W-1:0] i_instr_addr,   // pc
   output logic [mem_pkg::WORD_W-1:0] o_instr,
   output logic                       o_i_busy,
   input  logic                       i_d_mem_en,
   input  logic                       i_d_wr_en,
   input  logic [mem_pkg::WORD_W-1:0] i_d_addr,
   input  logic [mem_pkg::WORD_W-1:0] i_d_wdata,
   output logic [mem_pkg::WORD_W-1:0] o_d_rdata,
   output logic                       o_d_busy
);
   import mem_pkg::*;

   localparam logic SEL_I = 1'b1;
   localparam logic SEL_D = 1'b0;

   // icache to arbiter
   logic              ic_req;
   logic              ic_valid;
   logic [WORD_W-1:0] ic_addr;

   // dcache to arbiter
   logic              dc_req;
   logic              dc_wr;
   logic              dc_valid;
   logic [WORD_W-1:0] dc_addr;
   logic [WORD_W-1:0] dc_wdata;

   // arbiter to memory
   logic              mem_en;
   logic              mem_wr;
   logic              mem_valid;
   logic [WORD_W-1:0] mem_addr;
   logic [WORD_W-1:0] mem_wdata;
   logic [WORD_W-1:0] mem_rdata;

   logic gnt_q;        // an access is owned until its valid pulse
   logic gnt_sel_q;    // which cache owns it
   logic en_q;

   icache icache0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_addr      (i_instr_addr),
      .i_mem_valid (ic_valid),
      .i_mem_rdata (mem_rdata),
      .o_data      (o_instr),
      .o_busy      (o_i_busy),
      .o_req       (ic_req),
      .o_addr      (ic_addr)
   );

   dcache dcache0 (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_mem_en    (i_d_mem_en),
      .i_wr_en     (i_d_wr_en),
      .i_addr      (i_d_addr),
      .i_wdata     (i_d_wdata),
      .i_mem_valid (dc_valid),
      .i_mem_rdata (mem_rdata),
      .o_data      (o_d_rdata),
      .o_busy      (o_d_busy),
      .o_req       (dc_req),
      .o_wr        (dc_wr),
      .o_addr      (dc_addr),
      .o_wdata     (dc_wdata)
   );

   multicycle_memory #(
      .MEM_LATENCY (MEM_LATENCY),
      .MEM_DEPTH_W (MEM_DEPTH_W)
   ) mem0 (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_en    (mem_en),
      .i_wr    (mem_wr),
      .i_addr  (mem_addr),
      .i_wdata (mem_wdata),
      .o_rdata (mem_rdata),
      .o_valid (mem_valid)
   );

   // instruction side wins when both ask in the same cycle
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         gnt_q     <= 1'b0;
         gnt_sel_q <= SEL_I;
         en_q      <= 1'b0;
      end else begin
         en_q <= 1'b0;
         if (!gnt_q && (ic_req || dc_req)) begin
            gnt_q     <= 1'b1;
            gnt_sel_q <= ic_req ? SEL_I : SEL_D;
            en_q      <= 1'b1;   // single start pulse per grant
         end else if (gnt_q && mem_valid) begin
            gnt_q <= 1'b0;
         end
      end
   end

   assign mem_en    = en_q;
   assign mem_addr  = (gnt_sel_q == SEL_I) ? ic_addr : dc_addr;
   assign mem_wr    = (gnt_sel_q == SEL_I) ? 1'b0 : dc_wr;   // icache never writes
   assign mem_wdata = (gnt_sel_q == SEL_I) ? '0 : dc_wdata;

   assign ic_valid = mem_valid && gnt_q && (gnt_sel_q == SEL_I);
   assign dc_valid = mem_valid && gnt_q && (gnt_sel_q == SEL_D);

endmodule

`default_nettype wire

// File: hdl/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_mem_en,      // read or write request level
   input  logic                       i_wr_en,
   input  logic [mem_pkg::WORD_W-1:0] i_addr,
   input  logic [mem_pkg::WORD_W-1:0] i_wdata,
   input  logic                       i_mem_valid,
   input  logic [mem_pkg::WORD_W-1:0] i_mem_rdata,
   output logic [mem_pkg::WORD_W-1:0] o_data,
   output logic                       o_busy,
   output logic                       o_req,
   output logic                       o_wr,
   output logic [mem_pkg::WORD_W-1:0] o_addr,
   output logic [mem_pkg::WORD_W-1:0] o_wdata
);
   import mem_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_FILL,     // read miss, fetching the line
      S_WRITE,    // write through in flight
      S_WDONE     // one cycle with busy low after the write
   } state_e;

   state_e state_q;

   cache_addr_u lookup_u;
   cache_addr_u fill_u;

   logic [NUM_LINES-1:0] valid_q;
   logic [TAG_W-1:0]     tag_q  [0:NUM_LINES-1];
   logic [WORD_W-1:0]    data_q [0:NUM_LINES*LINE_WORDS-1];

   logic                run_q;
   logic [OFFSET_W-1:0] word_q;
   logic                hit;
   logic                last_word;
   logic                rd_req;
   logic                wr_req;

   assign lookup_u.word = i_addr;

   assign hit = valid_q[lookup_u.fields.index] &&
                (tag_q[lookup_u.fields.index] == lookup_u.fields.tag);

   assign o_data = data_q[{lookup_u.fields.index, lookup_u.fields.offset}];

   always_comb begin
      fill_u = lookup_u;
      fill_u.fields.offset = word_q;
   end

   assign last_word = (word_q == OFFSET_W'(LINE_WORDS - 1));

   assign rd_req = run_q && i_mem_en && !i_wr_en;
   assign wr_req = run_q && i_mem_en && i_wr_en;

   // busy from the request cycle on, except for a read hit
   assign o_busy = (state_q == S_FILL) || (state_q == S_WRITE) ||
                   ((state_q == S_IDLE) && (wr_req || (rd_req && !hit)));

   assign o_req   = ((state_q == S_FILL) || (state_q == S_WRITE)) && !i_mem_valid;
   assign o_wr    = (state_q == S_WRITE);
   assign o_addr  = (state_q == S_WRITE) ? lookup_u.word : fill_u.word;
   assign o_wdata = i_wdata;   // requester holds it while busy

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= S_IDLE;
         run_q   <= 1'b0;
         word_q  <= '0;
         valid_q <= '0;
      end else begin
         run_q <= 1'b1;
         case (state_q)
            S_IDLE: begin
               if (wr_req) begin
                  state_q <= S_WRITE;
               end else if (rd_req && !hit) begin
                  state_q <= S_FILL;
                  word_q  <= '0;
                  valid_q[lookup_u.fields.index] <= 1'b0;
               end
            end
            S_FILL: begin
               if (i_mem_valid) begin
                  word_q <= word_q + 1'b1;
                  if (last_word) begin
                     valid_q[lookup_u.fields.index] <= 1'b1;
                     state_q <= S_IDLE;
                  end
               end
            end
            S_WRITE: begin
               if (i_mem_valid) begin
                  state_q <= S_WDONE;
               end
            end
            S_WDONE: state_q <= S_IDLE;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state_q == S_FILL) && i_mem_valid) begin
         data_q[{lookup_u.fields.index, word_q}] <= i_mem_rdata;
         if (last_word) begin
            tag_q[lookup_u.fields.index] <= lookup_u.fields.tag;
         end
      end else if ((state_q == S_WRITE) && i_mem_valid && hit) begin
         // write hit keeps the cached copy current, a miss leaves it alone
         data_q[{lookup_u.fields.index, lookup_u.fields.offset}] <= i_wdata;
      end
   end

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ns
`default_nettype none

module icache (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic [mem_pkg::WORD_W-1:0] i_addr,        // fetch address, held while busy
   input  logic                       i_mem_valid,
   input  logic [mem_pkg::WORD_W-1:0] i_mem_rdata,
   output logic [mem_pkg::WORD_W-1:0] o_data,
   output logic                       o_busy,
   output logic                       o_req,
   output logic [mem_pkg::WORD_W-1:0] o_addr
);
   import mem_pkg::*;

   typedef enum logic {
      S_IDLE,
      S_FILL
   } state_e;

   state_e state_q;

   cache_addr_u lookup_u;
   cache_addr_u fill_u;

   // storage
   logic [NUM_LINES-1:0] valid_q;
   logic [TAG_W-1:0]     tag_q  [0:NUM_LINES-1];
   logic [WORD_W-1:0]    data_q [0:NUM_LINES*LINE_WORDS-1];

   logic                run_q;      // set once reset is released
   logic [OFFSET_W-1:0] word_q;     // word of the line being fetched
   logic                hit;
   logic                last_word;

   assign lookup_u.word = i_addr;

   assign hit = valid_q[lookup_u.fields.index] &&
                (tag_q[lookup_u.fields.index] == lookup_u.fields.tag);

   assign o_data = data_q[{lookup_u.fields.index, lookup_u.fields.offset}];

   // same tag and index, offset walks the line
   always_comb begin
      fill_u = lookup_u;
      fill_u.fields.offset = word_q;
   end

   assign last_word = (word_q == OFFSET_W'(LINE_WORDS - 1));

   assign o_req  = (state_q == S_FILL) && !i_mem_valid;   // drops with each valid
   assign o_addr = fill_u.word;
   assign o_busy = (state_q == S_FILL) || (run_q && !hit);

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= S_IDLE;
         run_q   <= 1'b0;
         word_q  <= '0;
         valid_q <= '0;
      end else begin
         run_q <= 1'b1;
         case (state_q)
            S_IDLE: begin
               if (run_q && !hit) begin
                  state_q <= S_FILL;
                  word_q  <= '0;
                  valid_q[lookup_u.fields.index] <= 1'b0;   // line is being replaced
               end
            end
            S_FILL: begin
               if (i_mem_valid) begin
                  word_q <= word_q + 1'b1;
                  if (last_word) begin
                     valid_q[lookup_u.fields.index] <= 1'b1;
                     state_q <= S_IDLE;
                  end
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // line data and tag written as the words come back
   always_ff @(posedge clk) begin
      if ((state_q == S_FILL) && i_mem_valid) begin
         data_q[{lookup_u.fields.index, word_q}] <= i_mem_rdata;
         if (last_word) begin
            tag_q[lookup_u.fields.index] <= lookup_u.fields.tag;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/multicycle_memory.sv
`timescale 1ns/1ns
`default_nettype none

module multicycle_memory #(
   parameter int MEM_LATENCY = 4,
   parameter int MEM_DEPTH_W = 10
) (
   input  logic                       clk,
   input  logic                       i_rst_n,
   input  logic                       i_en,       // one-cycle start of an access
   input  logic                       i_wr,
   input  logic [mem_pkg::WORD_W-1:0] i_addr,
   input  logic [mem_pkg::WORD_W-1:0] i_wdata,
   output logic [mem_pkg::WORD_W-1:0] o_rdata,
   output logic                       o_valid     // one-cycle done pulse
);
   import mem_pkg::*;

   localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;
   localparam int DEPTH = 2 ** MEM_DEPTH_W;

   logic [WORD_W-1:0] mem_q [0:DEPTH-1];

   logic                   busy_q;
   logic [CNT_W-1:0]       cnt_q;     // cycles left before the pulse
   logic                   wr_q;
   logic [MEM_DEPTH_W-1:0] addr_q;    // high address bits dropped
   logic [WORD_W-1:0]      wdata_q;

   // final count reached
   assign o_valid = busy_q && (cnt_q == '0);
   assign o_rdata = mem_q[addr_q];

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         wr_q   <= 1'b0;
      end else if (i_en) begin
         busy_q <= 1'b1;
         cnt_q  <= CNT_W'(MEM_LATENCY - 1);
         wr_q   <= i_wr;
      end else if (o_valid) begin
         busy_q <= 1'b0;
      end else if (busy_q) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // access captured on the start pulse
   always_ff @(posedge clk) begin
      if (i_en) begin
         addr_q  <= i_addr[MEM_DEPTH_W-1:0];
         wdata_q <= i_wdata;
      end
   end

   // write lands at the end of the valid cycle
   always_ff @(posedge clk) begin
      if (o_valid && wr_q) begin
         mem_q[addr_q] <= wdata_q;
      end
   end

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

   // data and address width
   localparam int WORD_W = 16;

   // address split for both caches
   localparam int OFFSET_W = 2;
   localparam int INDEX_W  = 3;
   localparam int TAG_W    = WORD_W - INDEX_W - OFFSET_W;   // 11 bits

   localparam int LINE_WORDS = 1 << OFFSET_W;   // words per line
   localparam int NUM_LINES  = 1 << INDEX_W;    // lines per cache

   // field order matches the address bits, msb first
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } cache_addr_s;

   // one address word, seen flat or as tag/index/offset
   typedef union packed {
      logic [WORD_W-1:0] word;
      cache_addr_s       fields;
   } cache_addr_u;

endpackage

`default_nettype wire
